// ==== common/csr_cfg.svh ====
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// Widths
`define CSR_XLEN                32
`define CSR_REG_IDX_W           5
`define CSR_ADDR_W              12
`define CSR_CAUSE_W             5
`define CSR_CNT_W               64

// CSR addresses
`define CSR_ADDR_MSTATUS        12'h300
`define CSR_ADDR_MIE            12'h304
`define CSR_ADDR_MTVEC          12'h305
`define CSR_ADDR_MSCRATCH       12'h340
`define CSR_ADDR_MEPC           12'h341
`define CSR_ADDR_MCAUSE         12'h342
`define CSR_ADDR_MCYCLE         12'hB00
`define CSR_ADDR_MCYCLEH        12'hB80
`define CSR_ADDR_CYCLE          12'hC00

// Writable bits per CSR
`define CSR_MASK_MSTATUS        32'h0000_1888
`define CSR_MASK_MIE            32'h0000_0888
`define CSR_MASK_MTVEC          32'hFFFF_FFFC
`define CSR_MASK_MEPC           32'hFFFF_FFFC
`define CSR_MASK_MCAUSE         32'h8000_001F
`define CSR_MASK_MSCRATCH       32'hFFFF_FFFF
`define CSR_MASK_MCYCLE         32'hFFFF_FFFF
`define CSR_MASK_MCYCLEH        32'hFFFF_FFFF

// Exception cause codes
`define CSR_CAUSE_MISALIGNED_FETCH  5'd0
`define CSR_CAUSE_ILLEGAL_INSTR     5'd2
`define CSR_CAUSE_BREAKPOINT        5'd3
`define CSR_CAUSE_MISALIGNED_LOAD   5'd4
`define CSR_CAUSE_LOAD_FAULT        5'd5
`define CSR_CAUSE_MISALIGNED_STORE  5'd6
`define CSR_CAUSE_STORE_FAULT       5'd7
`define CSR_CAUSE_ECALL_M           5'd11

// SYSTEM major opcode and the fixed encodings under it
`define CSR_OPC_SYSTEM          7'b1110011
`define CSR_INSTR_ECALL         32'h0000_0073
`define CSR_INSTR_EBREAK        32'h0010_0073
`define CSR_INSTR_MRET          32'h3020_0073

// mstatus fields
`define CSR_MSTATUS_MIE         3
`define CSR_MSTATUS_MPIE        7
`define CSR_MSTATUS_MPP_LO      11
`define CSR_MSTATUS_MPP_HI      12

`endif

// ==== common/csr_pkg.sv ====
package csr_pkg;

`include "csr_cfg.svh"

    // --------------------------------------------------
    // Pipeline-facing bundles
    // --------------------------------------------------
    typedef struct packed {
        logic                   valid;
        logic [`CSR_XLEN-1:0]   instr;      // Raw 32-bit opcode
        logic [`CSR_XLEN-1:0]   pc;
        logic [`CSR_XLEN-1:0]   rs1_val;    // rs1 operand from the register file
    } opcode_in_t;

    typedef struct packed {
        logic misaligned_load;
        logic load_fault;
        logic misaligned_store;
        logic store_fault;
    } lsu_fault_t;

    typedef struct packed {
        logic                       valid;
        logic [`CSR_REG_IDX_W-1:0]  rd;
        logic [`CSR_XLEN-1:0]       value;
        logic                       squash;     // Set when rd is x0
    } wb_t;

    typedef struct packed {
        logic                   req;
        logic [`CSR_XLEN-1:0]   pc;
    } redirect_t;

    // --------------------------------------------------
    // Internal decode and control types
    // --------------------------------------------------
    // Encoding matches funct3[1:0] of the CSR instructions
    typedef enum logic [1:0] {
        CSR_OP_NONE  = 2'd0,
        CSR_OP_WRITE = 2'd1,
        CSR_OP_SET   = 2'd2,
        CSR_OP_CLEAR = 2'd3
    } csr_op_e;

    typedef enum logic [2:0] {
        KIND_NONE,
        KIND_CSR,
        KIND_ECALL,
        KIND_EBREAK,
        KIND_MRET,
        KIND_ILLEGAL
    } instr_kind_e;

    typedef struct packed {
        csr_op_e                    op;
        logic [`CSR_ADDR_W-1:0]     addr;
        logic [`CSR_REG_IDX_W-1:0]  rd;
        logic [`CSR_XLEN-1:0]       src;        // rs1 value or zero-extended uimm
        logic                       writes;
    } csr_req_t;

    typedef enum logic [1:0] {
        CMD_IDLE,
        CMD_ACCESS,
        CMD_TRAP,
        CMD_RETURN
    } csr_cmd_e;

    typedef struct packed {
        csr_cmd_e                   cmd;
        logic [`CSR_CAUSE_W-1:0]    cause;
        logic [`CSR_XLEN-1:0]       epc;
    } trap_cmd_t;

endpackage

// ==== csr_file/csr_cycle_counter.sv ====
`include "csr_cfg.svh"

module csr_cycle_counter (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    load_lo_i,
    input  logic                    load_hi_i,
    input  logic [`CSR_XLEN-1:0]    wdata_i,
    output logic [`CSR_CNT_W-1:0]   count_o
);

    logic [`CSR_CNT_W-1:0] count;

    // --------------------------------------------------
    // Free-running count with software load per half
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            count <= '0;
        end else if (load_lo_i) begin
            count[`CSR_XLEN-1:0] <= wdata_i;            // Upper half holds
        end else if (load_hi_i) begin
            count[`CSR_CNT_W-1:`CSR_XLEN] <= wdata_i;   // Lower half holds
        end else begin
            count <= count + 1'b1;
        end
    end

    assign count_o = count;

    // One CSR access per cycle, so both halves never load together
    a_single_load: assert property (@(posedge clk_i) disable iff (rst_i)
        !(load_lo_i && load_hi_i));

endmodule

// ==== csr_file/csr_file.sv ====
`include "csr_cfg.svh"

module csr_file (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic [`CSR_XLEN-1:0]    reset_vector_i,
    input  csr_pkg::trap_cmd_t      cmd_i,
    input  csr_pkg::csr_req_t       req_i,
    output logic [`CSR_XLEN-1:0]    rdata_o,
    output logic [`CSR_XLEN-1:0]    mtvec_o,
    output logic [`CSR_XLEN-1:0]    mepc_o
);
    import csr_pkg::*;

    logic [`CSR_XLEN-1:0]   mstatus;
    logic [`CSR_XLEN-1:0]   mie;
    logic [`CSR_XLEN-1:0]   mtvec;
    logic [`CSR_XLEN-1:0]   mscratch;
    logic [`CSR_XLEN-1:0]   mepc;
    logic [`CSR_XLEN-1:0]   mcause;
    logic [`CSR_CNT_W-1:0]  cycle_cnt;

    logic [`CSR_XLEN-1:0]   rdata;
    logic [`CSR_XLEN-1:0]   wmask;
    logic [`CSR_XLEN-1:0]   wval;
    logic [`CSR_XLEN-1:0]   wdata;
    logic                   addr_hit;
    logic                   do_write;
    logic                   load_lo;
    logic                   load_hi;

    // --------------------------------------------------
    // Read mux and write mask lookup
    // --------------------------------------------------
    always_comb begin
        rdata    = '0;
        wmask    = '0;
        addr_hit = 1'b1;
        case (req_i.addr)
            `CSR_ADDR_MSTATUS:  begin rdata = mstatus;  wmask = `CSR_MASK_MSTATUS;  end
            `CSR_ADDR_MIE:      begin rdata = mie;      wmask = `CSR_MASK_MIE;      end
            `CSR_ADDR_MTVEC:    begin rdata = mtvec;    wmask = `CSR_MASK_MTVEC;    end
            `CSR_ADDR_MSCRATCH: begin rdata = mscratch; wmask = `CSR_MASK_MSCRATCH; end
            `CSR_ADDR_MEPC:     begin rdata = mepc;     wmask = `CSR_MASK_MEPC;     end
            `CSR_ADDR_MCAUSE:   begin rdata = mcause;   wmask = `CSR_MASK_MCAUSE;   end
            `CSR_ADDR_MCYCLE: begin
                rdata = cycle_cnt[`CSR_XLEN-1:0];
                wmask = `CSR_MASK_MCYCLE;
            end
            `CSR_ADDR_MCYCLEH: begin
                rdata = cycle_cnt[`CSR_CNT_W-1:`CSR_XLEN];
                wmask = `CSR_MASK_MCYCLEH;
            end
            `CSR_ADDR_CYCLE:    rdata = cycle_cnt[`CSR_XLEN-1:0];  // Read-only alias
            default:            addr_hit = 1'b0;
        endcase
    end

    // Access value before masking
    always_comb begin
        case (req_i.op)
            CSR_OP_WRITE: wval = req_i.src;
            CSR_OP_SET:   wval = rdata | req_i.src;
            CSR_OP_CLEAR: wval = rdata & ~req_i.src;
            default:      wval = rdata;
        endcase
    end

    assign wdata    = (rdata & ~wmask) | (wval & wmask);  // Bits outside the mask keep old value
    assign do_write = (cmd_i.cmd == CMD_ACCESS) && req_i.writes;
    assign load_lo  = do_write && (req_i.addr == `CSR_ADDR_MCYCLE);
    assign load_hi  = do_write && (req_i.addr == `CSR_ADDR_MCYCLEH);

    csr_cycle_counter u_cycle_counter (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .load_lo_i (load_lo),
        .load_hi_i (load_hi),
        .wdata_i   (wdata),
        .count_o   (cycle_cnt)
    );

    // --------------------------------------------------
    // State update
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mstatus  <= '0;
            mie      <= '0;
            mtvec    <= reset_vector_i;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
        end else if (do_write) begin
            case (req_i.addr)
                `CSR_ADDR_MSTATUS:  mstatus  <= wdata;
                `CSR_ADDR_MIE:      mie      <= wdata;
                `CSR_ADDR_MTVEC:    mtvec    <= wdata;
                `CSR_ADDR_MSCRATCH: mscratch <= wdata;
                `CSR_ADDR_MEPC:     mepc     <= wdata;
                `CSR_ADDR_MCAUSE:   mcause   <= wdata;
                default: ;                                // Counter halves load in the counter
            endcase
        end else if (cmd_i.cmd == CMD_TRAP) begin
            mcause <= {{(`CSR_XLEN-`CSR_CAUSE_W){1'b0}}, cmd_i.cause};
            mepc   <= cmd_i.epc & `CSR_MASK_MEPC;
            mstatus[`CSR_MSTATUS_MPIE] <= mstatus[`CSR_MSTATUS_MIE];
            mstatus[`CSR_MSTATUS_MIE]  <= 1'b0;
            mstatus[`CSR_MSTATUS_MPP_HI:`CSR_MSTATUS_MPP_LO] <= 2'b11;  // Machine mode
        end else if (cmd_i.cmd == CMD_RETURN) begin
            mstatus[`CSR_MSTATUS_MIE]  <= mstatus[`CSR_MSTATUS_MPIE];
            mstatus[`CSR_MSTATUS_MPIE] <= 1'b1;
        end
    end

    assign rdata_o = rdata;
    assign mtvec_o = mtvec;
    assign mepc_o  = mepc;

    // Decode must have turned unknown addresses into illegal-instruction traps
    a_access_implemented: assert property (@(posedge clk_i) disable iff (rst_i)
        (cmd_i.cmd == CMD_ACCESS) |-> addr_hit);

endmodule

// ==== design/csr_decode.sv ====
`include "csr_cfg.svh"

module csr_decode (
    input  csr_pkg::opcode_in_t     opcode_i,
    output csr_pkg::instr_kind_e    kind_o,
    output csr_pkg::csr_req_t       req_o
);
    import csr_pkg::*;

    logic [6:0]                 opc;
    logic [2:0]                 funct3;
    logic [`CSR_REG_IDX_W-1:0]  rd_idx;
    logic [`CSR_REG_IDX_W-1:0]  rs1_idx;
    logic [`CSR_ADDR_W-1:0]     addr;
    logic                       is_csr;
    logic                       implemented;
    logic                       writes;

    // --------------------------------------------------
    // Field extraction
    // --------------------------------------------------
    assign opc     = opcode_i.instr[6:0];
    assign rd_idx  = opcode_i.instr[11:7];
    assign funct3  = opcode_i.instr[14:12];
    assign rs1_idx = opcode_i.instr[19:15];
    assign addr    = opcode_i.instr[31:20];

    // funct3 of 000 and 100 are not CSR instructions
    assign is_csr = opcode_i.valid && (opc == `CSR_OPC_SYSTEM) && (funct3[1:0] != 2'b00);

    // CSRRW always writes, set/clear only with a nonzero rs1 field
    assign writes = (funct3[1:0] == 2'b01) || (rs1_idx != '0);

    // Implemented CSR list
    always_comb begin
        case (addr)
            `CSR_ADDR_MSTATUS, `CSR_ADDR_MIE, `CSR_ADDR_MTVEC,
            `CSR_ADDR_MSCRATCH, `CSR_ADDR_MEPC, `CSR_ADDR_MCAUSE,
            `CSR_ADDR_MCYCLE, `CSR_ADDR_MCYCLEH, `CSR_ADDR_CYCLE: implemented = 1'b1;
            default: implemented = 1'b0;
        endcase
    end

    always_comb begin
        kind_o = KIND_NONE;
        if (opcode_i.valid) begin
            if (opcode_i.instr == `CSR_INSTR_ECALL)       kind_o = KIND_ECALL;
            else if (opcode_i.instr == `CSR_INSTR_EBREAK) kind_o = KIND_EBREAK;
            else if (opcode_i.instr == `CSR_INSTR_MRET)   kind_o = KIND_MRET;
            else if (is_csr) begin
                if (!implemented || ((addr == `CSR_ADDR_CYCLE) && writes))
                    kind_o = KIND_ILLEGAL;
                else
                    kind_o = KIND_CSR;
            end
        end
    end

    always_comb begin
        req_o.op     = is_csr ? csr_op_e'(funct3[1:0]) : CSR_OP_NONE;
        req_o.addr   = addr;
        req_o.rd     = rd_idx;
        req_o.src    = funct3[2] ? {{(`CSR_XLEN-`CSR_REG_IDX_W){1'b0}}, rs1_idx}  // uimm form
                                 : opcode_i.rs1_val;
        req_o.writes = is_csr && writes;
    end

endmodule

// ==== design/trap_ctrl.sv ====
`include "csr_cfg.svh"

module trap_ctrl (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  csr_pkg::opcode_in_t     opcode_i,
    input  csr_pkg::instr_kind_e    kind_i,
    input  csr_pkg::csr_req_t       req_i,
    input  csr_pkg::lsu_fault_t     fault_i,
    input  logic [`CSR_XLEN-1:0]    rdata_i,
    input  logic [`CSR_XLEN-1:0]    mtvec_i,
    input  logic [`CSR_XLEN-1:0]    mepc_i,
    output csr_pkg::trap_cmd_t      cmd_o,
    output csr_pkg::wb_t            wb_o,
    output csr_pkg::redirect_t      redirect_o,
    output logic                    stall_o
);
    import csr_pkg::*;

    trap_cmd_t              cmd;
    logic                   pc_misaligned;
    logic [`CSR_XLEN-1:0]   trap_target;

    assign pc_misaligned = opcode_i.valid && (opcode_i.pc[1:0] != 2'b00);

    // --------------------------------------------------
    // Priority select, highest first
    // --------------------------------------------------
    always_comb begin
        cmd.cmd   = CMD_IDLE;
        cmd.cause = '0;
        cmd.epc   = opcode_i.pc;
        if (pc_misaligned) begin
            cmd.cmd   = CMD_TRAP;
            cmd.cause = `CSR_CAUSE_MISALIGNED_FETCH;
        end else if (kind_i == KIND_EBREAK) begin
            cmd.cmd   = CMD_TRAP;
            cmd.cause = `CSR_CAUSE_BREAKPOINT;
        end else if (kind_i == KIND_ECALL) begin
            cmd.cmd   = CMD_TRAP;
            cmd.cause = `CSR_CAUSE_ECALL_M;
        end else if (kind_i == KIND_MRET) begin
            cmd.cmd   = CMD_RETURN;
        end else if (fault_i != '0) begin  // LSU faults ignore valid
            cmd.cmd = CMD_TRAP;
            if (fault_i.misaligned_load)       cmd.cause = `CSR_CAUSE_MISALIGNED_LOAD;
            else if (fault_i.load_fault)       cmd.cause = `CSR_CAUSE_LOAD_FAULT;
            else if (fault_i.misaligned_store) cmd.cause = `CSR_CAUSE_MISALIGNED_STORE;
            else                               cmd.cause = `CSR_CAUSE_STORE_FAULT;
        end else if (kind_i == KIND_ILLEGAL) begin
            cmd.cmd   = CMD_TRAP;
            cmd.cause = `CSR_CAUSE_ILLEGAL_INSTR;
        end else if (kind_i == KIND_CSR) begin
            cmd.cmd   = CMD_ACCESS;
        end
    end

    assign cmd_o = cmd;  // Consumed by the register file at the same edge

    // Vectored entry at mtvec + 4 * cause
    assign trap_target = mtvec_i + {{(`CSR_XLEN-`CSR_CAUSE_W-2){1'b0}}, cmd.cause, 2'b00};

    // --------------------------------------------------
    // Registered outputs
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wb_o       <= '0;
            redirect_o <= '0;
            stall_o    <= 1'b0;
        end else begin
            wb_o       <= '0;
            redirect_o <= '0;
            stall_o    <= 1'b0;
            case (cmd.cmd)
                CMD_TRAP: begin
                    redirect_o.req <= 1'b1;
                    redirect_o.pc  <= trap_target;
                end
                CMD_RETURN: begin
                    redirect_o.req <= 1'b1;
                    redirect_o.pc  <= mepc_i;
                end
                CMD_ACCESS: begin
                    wb_o.valid  <= 1'b1;
                    wb_o.rd     <= req_i.rd;
                    wb_o.value  <= rdata_i;                 // Value before the access
                    wb_o.squash <= (req_i.rd == '0);
                    stall_o     <= 1'b1;
                end
                default: ;
            endcase
        end
    end

    a_stall_vs_redirect: assert property (@(posedge clk_i) disable iff (rst_i)
        !(stall_o && redirect_o.req));

    // mtvec and mepc masks keep every target word aligned
    a_redirect_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
        redirect_o.req |-> (redirect_o.pc[1:0] == 2'b00));

endmodule

// ==== design/csr_unit.sv ====
`include "csr_cfg.svh"

module csr_unit (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic [`CSR_XLEN-1:0]    reset_vector_i,
    input  csr_pkg::opcode_in_t     opcode_i,
    input  csr_pkg::lsu_fault_t     fault_i,
    output csr_pkg::wb_t            wb_o,
    output csr_pkg::redirect_t      redirect_o,
    output logic                    stall_o
);
    import csr_pkg::*;

    instr_kind_e            kind;
    csr_req_t               req;
    trap_cmd_t              cmd;
    logic [`CSR_XLEN-1:0]   rdata;
    logic [`CSR_XLEN-1:0]   mtvec;
    logic [`CSR_XLEN-1:0]   mepc;

    csr_decode u_decode (
        .opcode_i (opcode_i),
        .kind_o   (kind),
        .req_o    (req)
    );

    // Priority and registered pipeline outputs
    trap_ctrl u_trap_ctrl (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .opcode_i   (opcode_i),
        .kind_i     (kind),
        .req_i      (req),
        .fault_i    (fault_i),
        .rdata_i    (rdata),
        .mtvec_i    (mtvec),
        .mepc_i     (mepc),
        .cmd_o      (cmd),
        .wb_o       (wb_o),
        .redirect_o (redirect_o),
        .stall_o    (stall_o)
    );

    csr_file u_csr_file (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .reset_vector_i (reset_vector_i),
        .cmd_i          (cmd),
        .req_i          (req),
        .rdata_o        (rdata),
        .mtvec_o        (mtvec),
        .mepc_o         (mepc)
    );

endmodule

// ==== dv/csr_unit_tb.sv ====
`include "csr_cfg.svh"

module csr_unit_tb;
    import csr_pkg::*;

    localparam logic [31:0] RESET_VEC    = 32'h0000_1000;
    localparam logic [31:0] NOP_INSTR    = 32'h0000_0013;   // addi x0, x0, 0
    localparam int          RESET_CYCLES = 8;
    localparam int          N_ACCESS     = 200;
    localparam int          N_SQUASH     = 20;
    localparam int          N_TRAP       = 20;
    localparam int          N_PRIO       = 150;
    localparam int          N_ILLEGAL    = 30;
    localparam int          N_CYCLE      = 10;
    // One instruction per cycle, so the step count bounds the run time
    localparam int MAX_STEPS = N_ACCESS + 2 * N_SQUASH + 7 * N_TRAP + N_PRIO + N_ILLEGAL
                               + 12 * N_CYCLE;
    localparam int WATCHDOG_TIME = (MAX_STEPS + RESET_CYCLES) * 10 + 500;

    logic                   clk_i;
    logic                   rst_i;
    logic [`CSR_XLEN-1:0]   reset_vector_i;
    opcode_in_t             opcode_i;
    lsu_fault_t             fault_i;
    wb_t                    wb_o;
    redirect_t              redirect_o;
    logic                   stall_o;

    // Reference model state
    logic [31:0] m_mstatus;
    logic [31:0] m_mie;
    logic [31:0] m_mtvec;
    logic [31:0] m_mscratch;
    logic [31:0] m_mepc;
    logic [31:0] m_mcause;
    logic [63:0] m_cycle;
    int          n_checks;
    int          n_errors;
    int          test_checks;
    int          test_errors;

    csr_unit UUT (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .reset_vector_i (reset_vector_i),
        .opcode_i       (opcode_i),
        .fault_i        (fault_i),
        .wb_o           (wb_o),
        .redirect_o     (redirect_o),
        .stall_o        (stall_o)
    );

    always #5 clk_i = ~clk_i;

    // --------------------------------------------------
    // Model lookups
    // --------------------------------------------------
    function automatic logic is_implemented(input logic [11:0] addr);
        case (addr)
            `CSR_ADDR_MSTATUS, `CSR_ADDR_MIE, `CSR_ADDR_MTVEC, `CSR_ADDR_MSCRATCH,
            `CSR_ADDR_MEPC, `CSR_ADDR_MCAUSE, `CSR_ADDR_MCYCLE, `CSR_ADDR_MCYCLEH,
            `CSR_ADDR_CYCLE: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] read_model(input logic [11:0] addr);
        case (addr)
            `CSR_ADDR_MSTATUS:  return m_mstatus;
            `CSR_ADDR_MIE:      return m_mie;
            `CSR_ADDR_MTVEC:    return m_mtvec;
            `CSR_ADDR_MSCRATCH: return m_mscratch;
            `CSR_ADDR_MEPC:     return m_mepc;
            `CSR_ADDR_MCAUSE:   return m_mcause;
            `CSR_ADDR_MCYCLEH:  return m_cycle[63:32];
            default:            return m_cycle[31:0];   // mcycle and cycle
        endcase
    endfunction

    function automatic logic [31:0] mask_of(input logic [11:0] addr);
        case (addr)
            `CSR_ADDR_MSTATUS:  return `CSR_MASK_MSTATUS;
            `CSR_ADDR_MIE:      return `CSR_MASK_MIE;
            `CSR_ADDR_MTVEC:    return `CSR_MASK_MTVEC;
            `CSR_ADDR_MSCRATCH: return `CSR_MASK_MSCRATCH;
            `CSR_ADDR_MEPC:     return `CSR_MASK_MEPC;
            `CSR_ADDR_MCAUSE:   return `CSR_MASK_MCAUSE;
            `CSR_ADDR_MCYCLE:   return `CSR_MASK_MCYCLE;
            `CSR_ADDR_MCYCLEH:  return `CSR_MASK_MCYCLEH;
            default:            return 32'h0;
        endcase
    endfunction

    // Expected outputs for one input, then advance the model by one cycle
    task automatic predict(input logic valid, input logic [31:0] instr, input logic [31:0] pc,
                           input logic [31:0] rs1_val, input lsu_fault_t fault,
                           output wb_t exp_wb, output redirect_t exp_redir,
                           output logic exp_stall);
        logic [2:0]  f3;
        logic [4:0]  rs1;
        logic [4:0]  rd;
        logic [11:0] addr;
        logic [31:0] src;
        logic [31:0] old;
        logic [31:0] val;
        logic [31:0] mask;
        logic        csr_op;
        logic        wr;
        logic        trap;
        logic [4:0]  cause;
        logic        cnt_loaded;

        f3         = instr[14:12];
        rd         = instr[11:7];
        rs1        = instr[19:15];
        addr       = instr[31:20];
        csr_op     = valid && (instr[6:0] == `CSR_OPC_SYSTEM) && (f3[1:0] != 2'b00);
        wr         = (f3[1:0] == 2'b01) || (rs1 != 5'd0);
        src        = f3[2] ? {27'd0, rs1} : rs1_val;      // Immediate forms use the rs1 field
        exp_wb     = '0;
        exp_redir  = '0;
        exp_stall  = 1'b0;
        trap       = 1'b0;
        cause      = '0;
        cnt_loaded = 1'b0;

        if (valid && (pc[1:0] != 2'b00)) begin
            trap  = 1'b1;
            cause = `CSR_CAUSE_MISALIGNED_FETCH;
        end else if (valid && (instr == `CSR_INSTR_EBREAK)) begin
            trap  = 1'b1;
            cause = `CSR_CAUSE_BREAKPOINT;
        end else if (valid && (instr == `CSR_INSTR_ECALL)) begin
            trap  = 1'b1;
            cause = `CSR_CAUSE_ECALL_M;
        end else if (valid && (instr == `CSR_INSTR_MRET)) begin
            exp_redir.req = 1'b1;
            exp_redir.pc  = m_mepc;
            m_mstatus[`CSR_MSTATUS_MIE]  = m_mstatus[`CSR_MSTATUS_MPIE];
            m_mstatus[`CSR_MSTATUS_MPIE] = 1'b1;
        end else if (fault != '0) begin
            trap = 1'b1;
            if (fault.misaligned_load)       cause = `CSR_CAUSE_MISALIGNED_LOAD;
            else if (fault.load_fault)       cause = `CSR_CAUSE_LOAD_FAULT;
            else if (fault.misaligned_store) cause = `CSR_CAUSE_MISALIGNED_STORE;
            else                             cause = `CSR_CAUSE_STORE_FAULT;
        end else if (csr_op) begin
            if (!is_implemented(addr) || ((addr == `CSR_ADDR_CYCLE) && wr)) begin
                trap  = 1'b1;
                cause = `CSR_CAUSE_ILLEGAL_INSTR;
            end else begin
                old              = read_model(addr);
                exp_wb.valid     = 1'b1;
                exp_wb.rd        = rd;
                exp_wb.value     = old;
                exp_wb.squash    = (rd == 5'd0);
                exp_stall        = 1'b1;
                if (wr) begin
                    case (f3[1:0])
                        2'b01:   val = src;
                        2'b10:   val = old | src;
                        default: val = old & ~src;
                    endcase
                    mask = mask_of(addr);
                    val  = (old & ~mask) | (val & mask);
                    case (addr)
                        `CSR_ADDR_MSTATUS:  m_mstatus  = val;
                        `CSR_ADDR_MIE:      m_mie      = val;
                        `CSR_ADDR_MTVEC:    m_mtvec    = val;
                        `CSR_ADDR_MSCRATCH: m_mscratch = val;
                        `CSR_ADDR_MEPC:     m_mepc     = val;
                        `CSR_ADDR_MCAUSE:   m_mcause   = val;
                        `CSR_ADDR_MCYCLE: begin
                            m_cycle[31:0] = val;
                            cnt_loaded    = 1'b1;
                        end
                        `CSR_ADDR_MCYCLEH: begin
                            m_cycle[63:32] = val;
                            cnt_loaded     = 1'b1;
                        end
                        default: ;
                    endcase
                end
            end
        end

        if (trap) begin
            exp_redir.req = 1'b1;
            exp_redir.pc  = m_mtvec + {25'd0, cause, 2'b00};
            m_mcause      = {27'd0, cause};
            m_mepc        = pc & `CSR_MASK_MEPC;
            m_mstatus[`CSR_MSTATUS_MPIE] = m_mstatus[`CSR_MSTATUS_MIE];
            m_mstatus[`CSR_MSTATUS_MIE]  = 1'b0;
            m_mstatus[`CSR_MSTATUS_MPP_HI:`CSR_MSTATUS_MPP_LO] = 2'b11;
        end
        if (!cnt_loaded)
            m_cycle = m_cycle + 64'd1;
    endtask

    // --------------------------------------------------
    // Stimulus and checking
    // --------------------------------------------------
    task automatic check_outputs(input wb_t exp_wb, input redirect_t exp_redir,
                                 input logic exp_stall);
        n_checks++;
        assert (wb_o === exp_wb) else begin
            $display("Mismatch wb_o: expected %h, got %h", exp_wb, wb_o);
            n_errors++;
        end
        assert (redirect_o === exp_redir) else begin
            $display("Mismatch redirect_o: expected %h, got %h", exp_redir, redirect_o);
            n_errors++;
        end
        assert (stall_o === exp_stall) else begin
            $display("Mismatch stall_o: expected %h, got %h", exp_stall, stall_o);
            n_errors++;
        end
    endtask

    // Called 1 unit after a rising edge, returns 1 unit after the next one
    task automatic run_step(input logic valid, input logic [31:0] instr, input logic [31:0] pc,
                            input logic [31:0] rs1_val, input lsu_fault_t fault);
        wb_t       exp_wb;
        redirect_t exp_redir;
        logic      exp_stall;

        opcode_i.valid   = valid;
        opcode_i.instr   = instr;
        opcode_i.pc      = pc;
        opcode_i.rs1_val = rs1_val;
        fault_i          = fault;
        predict(valid, instr, pc, rs1_val, fault, exp_wb, exp_redir, exp_stall);
        @(posedge clk_i);
        #1;
        check_outputs(exp_wb, exp_redir, exp_stall);
    endtask

    task automatic issue(input logic [31:0] instr, input logic [31:0] rs1_val);
        run_step(1'b1, instr, $urandom & 32'hFFFF_FFFC, rs1_val, '0);
    endtask

    task automatic idle();
        run_step(1'b0, NOP_INSTR, 32'h0, 32'h0, '0);
    endtask

    task automatic end_test(input string name);
        $display("%-10s %0d checks, %0d errors", name, n_checks - test_checks,
                 n_errors - test_errors);
        test_checks = n_checks;
        test_errors = n_errors;
    endtask

    function automatic logic [31:0] make_csr_instr(input logic [2:0] f3, input logic [11:0] addr,
                                                   input logic [4:0] rs1, input logic [4:0] rd);
        return {addr, rs1, f3, rd, `CSR_OPC_SYSTEM};
    endfunction

    // CSRRW/S/C and the three immediate forms
    function automatic logic [2:0] rand_funct3();
        logic [2:0] f3;
        f3    = 3'(($urandom % 3) + 1);
        f3[2] = 1'($urandom % 2);
        return f3;
    endfunction

    function automatic logic [11:0] rand_csr_addr();
        case ($urandom % 6)
            0:       return `CSR_ADDR_MSTATUS;
            1:       return `CSR_ADDR_MIE;
            2:       return `CSR_ADDR_MTVEC;
            3:       return `CSR_ADDR_MSCRATCH;
            4:       return `CSR_ADDR_MEPC;
            default: return `CSR_ADDR_MCAUSE;
        endcase
    endfunction

    function automatic logic [11:0] rand_unimpl_addr();
        logic [11:0] addr;
        do begin
            addr = 12'($urandom % 4096);
        end while (is_implemented(addr));
        return addr;
    endfunction

    initial begin
        #(WATCHDOG_TIME);
        $display("Watchdog expired after %0d time units before the tests finished",
                 WATCHDOG_TIME);
        $display("Test failed");
        $finish;
    end

    initial begin
        int          k;
        logic [31:0] val;
        logic [31:0] instr;
        logic [31:0] pc;
        lsu_fault_t  flt;
        logic        valid;

        void'($urandom(32'he6ea15c2));
        clk_i          = 1'b0;
        rst_i          = 1'b1;
        reset_vector_i = RESET_VEC;
        opcode_i       = '0;
        fault_i        = '0;
        n_checks       = 0;
        n_errors       = 0;
        test_checks    = 0;
        test_errors    = 0;
        m_mstatus      = '0;
        m_mie          = '0;
        m_mtvec        = RESET_VEC;
        m_mscratch     = '0;
        m_mepc         = '0;
        m_mcause       = '0;
        m_cycle        = '0;

        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        check_outputs('0, '0, 1'b0);
        end_test("reset");

        for (int i = 0; i < N_ACCESS; i++)
            issue(make_csr_instr(rand_funct3(), rand_csr_addr(), 5'($urandom % 32),
                                 5'($urandom % 32)), $urandom);
        end_test("access");

        for (int i = 0; i < N_SQUASH; i++) begin
            issue(make_csr_instr(3'b001, `CSR_ADDR_MSCRATCH, 5'd9, 5'd0), $urandom); // rd = x0
            issue(make_csr_instr(3'b010, `CSR_ADDR_MSCRATCH, 5'd0, 5'd3), 32'h0);
        end
        end_test("squash");

        for (int i = 0; i < N_TRAP; i++) begin
            issue(make_csr_instr(3'b001, `CSR_ADDR_MSTATUS, 5'd1, 5'd7), $urandom);
            instr = ($urandom % 2) ? `CSR_INSTR_ECALL : `CSR_INSTR_EBREAK;
            run_step(1'b1, instr, $urandom & 32'hFFFF_FFFC, 32'h0, '0);
            issue(make_csr_instr(3'b010, `CSR_ADDR_MEPC, 5'd0, 5'd5), 32'h0);
            issue(make_csr_instr(3'b010, `CSR_ADDR_MCAUSE, 5'd0, 5'd5), 32'h0);
            issue(make_csr_instr(3'b010, `CSR_ADDR_MSTATUS, 5'd0, 5'd5), 32'h0);
            issue(`CSR_INSTR_MRET, 32'h0);
            issue(make_csr_instr(3'b010, `CSR_ADDR_MSTATUS, 5'd0, 5'd5), 32'h0);
        end
        end_test("trap");

        for (int i = 0; i < N_PRIO; i++) begin
            valid = ($urandom % 4) != 0;
            pc    = ($urandom % 4 == 0) ? $urandom : ($urandom & 32'hFFFF_FFFC);
            flt   = ($urandom % 2) ? 4'($urandom % 16) : 4'h0;
            case ($urandom % 6)
                0:       instr = `CSR_INSTR_ECALL;
                1:       instr = `CSR_INSTR_EBREAK;
                2:       instr = `CSR_INSTR_MRET;
                3:       instr = make_csr_instr(rand_funct3(), rand_csr_addr(), 5'd4, 5'd6);
                4:       instr = make_csr_instr(rand_funct3(), rand_unimpl_addr(), 5'd4, 5'd6);
                default: instr = NOP_INSTR;
            endcase
            run_step(valid, instr, pc, $urandom, flt);
        end
        end_test("priority");

        for (int i = 0; i < N_ILLEGAL; i++) begin
            if ($urandom % 2)
                instr = make_csr_instr(rand_funct3(), rand_unimpl_addr(), 5'($urandom % 32),
                                       5'd8);
            else
                instr = make_csr_instr(rand_funct3(), `CSR_ADDR_CYCLE,
                                       5'(($urandom % 31) + 1), 5'd8);    // Nonzero rs1 writes
            issue(instr, $urandom);
        end
        end_test("illegal");

        for (int i = 0; i < N_CYCLE; i++) begin
            val = $urandom;
            issue(make_csr_instr(3'b001, `CSR_ADDR_MCYCLE, 5'd1, 5'd2), val);
            issue(make_csr_instr(3'b001, `CSR_ADDR_MCYCLEH, 5'd1, 5'd2), $urandom);
            k = $urandom % 8;
            repeat (k) idle();
            issue(make_csr_instr(3'b010, `CSR_ADDR_MCYCLE, 5'd0, 5'd3), 32'h0);
            n_checks++;
            assert (wb_o.value === val + k) else begin
                $display("Mismatch wb_o.value: expected %h, got %h", val + k, wb_o.value);
                n_errors++;
            end
            issue(make_csr_instr(3'b010, `CSR_ADDR_MCYCLEH, 5'd0, 5'd3), 32'h0);
            issue(make_csr_instr(3'b010, `CSR_ADDR_CYCLE, 5'd0, 5'd4), 32'h0);
        end
        end_test("cycle");

        $display("Total: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+common
common/csr_pkg.sv
csr_file/csr_cycle_counter.sv
csr_file/csr_file.sv
design/csr_decode.sv
design/trap_ctrl.sv
design/csr_unit.sv
dv/csr_unit_tb.sv
